//--- src.f
+incdir+include
source/icache_pkg.sv
source/icache_store.sv
source/icache_ctrl.sv
source/icache_perf.sv
source/icache_top.sv
test/mem_read_model.sv
test/icache_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= icache_tb
FILELIST ?= src.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary -Wno-fatal
PASS_TEXT ?= TEST PASSED

SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard include/*.svh)
BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

# fails unless the pass line shows up in the output
run: $(BIN)
	./$(BIN) | awk '{ print } $$0 == "$(PASS_TEXT)" { ok = 1 } END { exit !ok }'

clean:
	rm -rf $(BUILD_DIR)

//--- test/icache_tb.sv
`include "icache_settings.svh"

module icache_tb;

	localparam int MAX_CYCLES = 200 * 15 + 1000;
	localparam icache_pkg::axi_resp_t RESP_SLVERR = 2'b10;
	localparam int TAG_BITS = $bits(icache_pkg::line_tag_t);

	logic clk;
	logic rst;
	icache_pkg::fetch_addr_t ifu_araddr;
	logic ifu_arvalid;
	logic ifu_arready;
	icache_pkg::inst_word_t ifu_rdata;
	icache_pkg::axi_resp_t ifu_rresp;
	logic ifu_rvalid;
	logic ifu_rready;
	icache_pkg::fetch_addr_t out_araddr;
	logic out_arvalid;
	logic out_arready;
	icache_pkg::inst_word_t out_rdata;
	icache_pkg::axi_resp_t out_rresp;
	logic out_rvalid;
	logic out_rlast;
	logic out_rready;
	logic fence_i;
	icache_pkg::perf_cnt_t hit_count;
	icache_pkg::perf_cnt_t miss_count;

	int cycles;
	int checks;
	int errors;
	logic [31:0] lcg_state;
	icache_pkg::perf_cnt_t exp_hits;
	icache_pkg::perf_cnt_t exp_misses;
	// expected tags and valid bits
	logic model_valid [16];
	icache_pkg::line_tag_t model_tag [16];

	icache_top icache_top_inst (
		.clk(clk), .rst(rst),
		.ifu_araddr(ifu_araddr), .ifu_arvalid(ifu_arvalid), .ifu_arready(ifu_arready),
		.ifu_rdata(ifu_rdata), .ifu_rresp(ifu_rresp), .ifu_rvalid(ifu_rvalid),
		.ifu_rready(ifu_rready),
		.out_araddr(out_araddr), .out_arvalid(out_arvalid), .out_arready(out_arready),
		.out_rdata(out_rdata), .out_rresp(out_rresp), .out_rvalid(out_rvalid),
		.out_rlast(out_rlast), .out_rready(out_rready),
		.fence_i(fence_i), .hit_count(hit_count), .miss_count(miss_count)
	);

	mem_read_model mem_read_model_inst (
		.clk(clk), .rst(rst), .araddr(out_araddr), .arvalid(out_arvalid),
		.arready(out_arready), .rdata(out_rdata), .rresp(out_rresp),
		.rvalid(out_rvalid), .rlast(out_rlast), .rready(out_rready)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// hard stop if a handshake never comes
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("timeout: run still busy after %0d cycles", MAX_CYCLES);
			$display("TEST FAILED");
			$finish;
		end
	end

	// ------------------------------------------------------------------------
	// reference rules
	// ------------------------------------------------------------------------
	function automatic logic [31:0] next_random();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// memory word is the line address xor a fixed pattern
	function automatic icache_pkg::inst_word_t word_for(icache_pkg::fetch_addr_t addr);
		return {addr[31:2], 2'b00} ^ 32'h5a5a_0000;
	endfunction

	function automatic icache_pkg::axi_resp_t resp_for(icache_pkg::fetch_addr_t addr);
		return (addr >= 32'h0000_f000) ? RESP_SLVERR : `ICACHE_RESP_OKAY;
	endfunction

	function automatic logic predict_hit(icache_pkg::fetch_addr_t addr);
		int idx;
		idx = addr[`ICACHE_OFFSET_BITS +: `ICACHE_INDEX_BITS];
		return model_valid[idx] && (model_tag[idx] == addr[31 -: TAG_BITS]);
	endfunction

	task automatic clear_tags();
		for (int i = 0; i < 16; i++) begin
			model_valid[i] = 1'b0;
		end
	endtask

	// ------------------------------------------------------------------------
	// compare tasks
	// ------------------------------------------------------------------------
	task automatic check_word(string what, icache_pkg::inst_word_t got,
		icache_pkg::inst_word_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_resp(string what, icache_pkg::axi_resp_t got,
		icache_pkg::axi_resp_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("mismatch at %0t: %s got %b expected %b", $time, what, got, exp);
		end
	endtask

	task automatic check_count(string what, icache_pkg::perf_cnt_t got,
		icache_pkg::perf_cnt_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("mismatch at %0t: %s got %0d expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic check_flag(string what, logic got, logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("mismatch at %0t: %s got %b expected %b", $time, what, got, exp);
		end
	endtask

	// ------------------------------------------------------------------------
	// fetch port driver
	// ------------------------------------------------------------------------
	// sampled 1 unit after the falling edge, so everything has settled
	task automatic fetch(input icache_pkg::fetch_addr_t addr, input int stall,
		output icache_pkg::inst_word_t word, output icache_pkg::axi_resp_t resp,
		output logic hit);
		int held;
		logic seen;
		logic done;
		held = 0;
		seen = 1'b0;
		done = 1'b0;
		@(negedge clk);
		ifu_araddr = addr;
		ifu_arvalid = 1'b1;
		ifu_rready = (stall == 0);
		#1;
		while (!ifu_arready) begin
			@(negedge clk);
			#1;
		end
		// rvalid in the accept cycle only on a hit
		hit = ifu_rvalid;
		while (!done) begin
			if (ifu_rvalid) begin
				if (!seen) begin
					word = ifu_rdata;
					resp = ifu_rresp;
					seen = 1'b1;
				end else begin
					// stalled return must not move
					check_word($sformatf("held word @%h", addr), ifu_rdata, word);
					check_resp($sformatf("held resp @%h", addr), ifu_rresp, resp);
				end
				done = ifu_rready;
				held++;
			end
			@(negedge clk);
			ifu_arvalid = 1'b0;
			if (held >= stall) begin
				ifu_rready = 1'b1;
			end
			#1;
		end
	endtask

	task automatic fetch_and_check(icache_pkg::fetch_addr_t addr, int stall, logic exp_hit);
		icache_pkg::inst_word_t word;
		icache_pkg::axi_resp_t resp;
		logic hit;
		int idx;
		idx = addr[`ICACHE_OFFSET_BITS +: `ICACHE_INDEX_BITS];
		fetch(addr, stall, word, resp, hit);
		check_flag($sformatf("same cycle hit @%h", addr), hit, exp_hit);
		check_word($sformatf("word @%h", addr), word, word_for(addr));
		check_resp($sformatf("resp @%h", addr), resp, resp_for(addr));
		if (exp_hit) begin
			exp_hits = exp_hits + 32'd1;
		end else begin
			exp_misses = exp_misses + 32'd1;
		end
		check_count("hit_count", hit_count, exp_hits);
		check_count("miss_count", miss_count, exp_misses);
		// error fills never become valid
		if (!exp_hit && resp_for(addr) == `ICACHE_RESP_OKAY) begin
			model_valid[idx] = 1'b1;
			model_tag[idx] = addr[31 -: TAG_BITS];
		end
	endtask

	// ------------------------------------------------------------------------
	// directed tests
	// ------------------------------------------------------------------------
	task automatic miss_then_hit();
		fetch_and_check(32'h0000_0100, 0, 1'b0);
		fetch_and_check(32'h0000_0100, 0, 1'b1);
	endtask

	// same index 0, tags differ
	// odd fetches carry a byte offset
	task automatic conflict_misses();
		for (int i = 0; i < 6; i++) begin
			fetch_and_check((i % 2 == 0) ? 32'h0000_0200 : 32'h0000_0242, 0, 1'b0);
		end
	endtask

	task automatic fence_in_idle();
		for (int i = 0; i < 4; i++) begin
			fetch_and_check(32'h0000_0300 + i * 4, 0, 1'b0);
		end
		fetch_and_check(32'h0000_0304, 0, 1'b1);
		@(negedge clk);
		fence_i = 1'b1;
		#1;
		check_flag("arready during fence", ifu_arready, 1'b0);
		@(negedge clk);
		fence_i = 1'b0;
		clear_tags();
		for (int i = 0; i < 4; i++) begin
			fetch_and_check(32'h0000_0300 + i * 4, 0, 1'b0);
		end
	endtask

	// pulse lands while the cache sits in ST_REQ
	task automatic fence_during_miss();
		fork
			fetch_and_check(32'h0000_0700, 0, 1'b0);
			begin
				repeat (2) @(negedge clk);
				fence_i = 1'b1;
				@(negedge clk);
				fence_i = 1'b0;
			end
		join
		// first idle cycle runs the deferred flush
		check_flag("arready in deferred fence cycle", ifu_arready, 1'b0);
		clear_tags();
		fetch_and_check(32'h0000_0700, 0, 1'b0);
	endtask

	task automatic error_and_stall();
		fetch_and_check(32'h0000_f100, 0, 1'b0);
		fetch_and_check(32'h0000_f100, 1 + next_random() % 4, 1'b0);
		fetch_and_check(32'h0000_0500, 1 + next_random() % 4, 1'b0);
		fetch_and_check(32'h0000_0500, 1 + next_random() % 4, 1'b1);
	endtask

	// 64 words over 16 lines, plenty of conflicts
	task automatic random_sequence();
		icache_pkg::fetch_addr_t addr;
		for (int i = 0; i < 150; i++) begin
			addr = 32'h0000_2000 + ((next_random() >> 16) % 64) * 4;
			fetch_and_check(addr, (next_random() >> 16) % 3, predict_hit(addr));
		end
	endtask

	initial begin
		rst = 1'b1;
		ifu_araddr = '0;
		ifu_arvalid = 1'b0;
		ifu_rready = 1'b1;
		fence_i = 1'b0;
		cycles = 0;
		checks = 0;
		errors = 0;
		lcg_state = 32'h84c5;
		exp_hits = '0;
		exp_misses = '0;
		clear_tags();
		repeat (5) @(negedge clk);
		rst = 1'b0;
		check_count("hit_count after reset", hit_count, exp_hits);
		check_count("miss_count after reset", miss_count, exp_misses);
		check_flag("arready after reset", ifu_arready, 1'b1);
		check_flag("rvalid after reset", ifu_rvalid, 1'b0);
		check_flag("out_arvalid after reset", out_arvalid, 1'b0);
		check_flag("out_rready after reset", out_rready, 1'b0);
		miss_then_hit();
		conflict_misses();
		fence_in_idle();
		fence_during_miss();
		error_and_stall();
		random_sequence();
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

//--- test/mem_read_model.sv
`include "icache_settings.svh"

module mem_read_model (
	input logic clk,
	input logic rst,
	input icache_pkg::fetch_addr_t araddr,
	input logic arvalid,
	output logic arready,
	output icache_pkg::inst_word_t rdata,
	output icache_pkg::axi_resp_t rresp,
	output logic rvalid,
	output logic rlast,
	input logic rready
);

	localparam int LATENCY = 3;
	localparam icache_pkg::axi_resp_t RESP_SLVERR = 2'b10;

	// one read in flight at a time
	logic busy;
	int delay;
	icache_pkg::fetch_addr_t addr_q;

	assign arready = !busy;
	// single beat, so every beat is the last
	assign rlast = rvalid;
	assign rdata = addr_q ^ 32'h5a5a_0000;
	// top of the map answers with an error
	assign rresp = (addr_q >= 32'h0000_f000) ? RESP_SLVERR : `ICACHE_RESP_OKAY;

	always_ff @(posedge clk) begin
		if (rst) begin
			busy <= 1'b0;
			rvalid <= 1'b0;
			delay <= 0;
		end else if (!busy) begin
			if (arvalid) begin
				busy <= 1'b1;
				addr_q <= araddr;
				delay <= LATENCY;
			end
		end else if (rvalid) begin
			if (rready) begin
				rvalid <= 1'b0;
				busy <= 1'b0;
			end
		end else if (delay > 1) begin
			delay <= delay - 1;
		end else begin
			rvalid <= 1'b1;
		end
	end

endmodule

//--- source/icache_top.sv
module icache_top (
	input logic clk,
	input logic rst,
	// fetch port
	input icache_pkg::fetch_addr_t ifu_araddr,
	input logic ifu_arvalid,
	output logic ifu_arready,
	output icache_pkg::inst_word_t ifu_rdata,
	output icache_pkg::axi_resp_t ifu_rresp,
	output logic ifu_rvalid,
	input logic ifu_rready,
	// memory port
	output icache_pkg::fetch_addr_t out_araddr,
	output logic out_arvalid,
	input logic out_arready,
	input icache_pkg::inst_word_t out_rdata,
	input icache_pkg::axi_resp_t out_rresp,
	input logic out_rvalid,
	input logic out_rlast,
	output logic out_rready,
	input logic fence_i,
	// counters
	output icache_pkg::perf_cnt_t hit_count,
	output icache_pkg::perf_cnt_t miss_count
);

	icache_pkg::line_index_t rd_index;
	icache_pkg::line_tag_t rd_tag;
	icache_pkg::lookup_t lookup;
	icache_pkg::fill_t fill;
	logic flush;
	logic hit_evt;
	logic miss_evt;

	// ------------------------------------------------------------------------
	// tag, valid and data arrays
	// ------------------------------------------------------------------------
	icache_store icache_store_inst (
		.clk(clk),
		.rst(rst),
		.rd_index(rd_index),
		.rd_tag(rd_tag),
		.lookup(lookup),
		.fill(fill),
		.flush(flush)
	);

	// port handshakes and miss handling
	icache_ctrl icache_ctrl_inst (
		.clk(clk),
		.rst(rst),
		.ifu_araddr(ifu_araddr),
		.ifu_arvalid(ifu_arvalid),
		.ifu_arready(ifu_arready),
		.ifu_rdata(ifu_rdata),
		.ifu_rresp(ifu_rresp),
		.ifu_rvalid(ifu_rvalid),
		.ifu_rready(ifu_rready),
		.out_araddr(out_araddr),
		.out_arvalid(out_arvalid),
		.out_arready(out_arready),
		.out_rdata(out_rdata),
		.out_rresp(out_rresp),
		.out_rvalid(out_rvalid),
		.out_rlast(out_rlast),
		.out_rready(out_rready),
		.fence_i(fence_i),
		.rd_index(rd_index),
		.rd_tag(rd_tag),
		.lookup(lookup),
		.fill(fill),
		.flush(flush),
		.hit_evt(hit_evt),
		.miss_evt(miss_evt)
	);

	// hit and miss counters
	icache_perf icache_perf_inst (
		.clk(clk),
		.rst(rst),
		.hit_evt(hit_evt),
		.miss_evt(miss_evt),
		.hit_count(hit_count),
		.miss_count(miss_count)
	);

endmodule

//--- source/icache_perf.sv
module icache_perf (
	input logic clk,
	input logic rst,
	input logic hit_evt,
	input logic miss_evt,
	output icache_pkg::perf_cnt_t hit_count,
	output icache_pkg::perf_cnt_t miss_count
);

	// ------------------------------------------------------------------------
	// event counters
	// ------------------------------------------------------------------------
	// both wrap silently at the top

	always_ff @(posedge clk) begin
		if (rst) begin
			hit_count <= '0;
		end else if (hit_evt) begin
			hit_count <= hit_count + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			miss_count <= '0;
		end else if (miss_evt) begin
			miss_count <= miss_count + 1'b1;
		end
	end

endmodule

//--- source/icache_ctrl.sv
`include "icache_settings.svh"

module icache_ctrl (
	input logic clk,
	input logic rst,
	// fetch port
	input icache_pkg::fetch_addr_t ifu_araddr,
	input logic ifu_arvalid,
	output logic ifu_arready,
	output icache_pkg::inst_word_t ifu_rdata,
	output icache_pkg::axi_resp_t ifu_rresp,
	output logic ifu_rvalid,
	input logic ifu_rready,
	// memory port
	output icache_pkg::fetch_addr_t out_araddr,
	output logic out_arvalid,
	input logic out_arready,
	input icache_pkg::inst_word_t out_rdata,
	input icache_pkg::axi_resp_t out_rresp,
	input logic out_rvalid,
	input logic out_rlast,
	output logic out_rready,
	input logic fence_i,
	// store side
	output icache_pkg::line_index_t rd_index,
	output icache_pkg::line_tag_t rd_tag,
	input icache_pkg::lookup_t lookup,
	output icache_pkg::fill_t fill,
	output logic flush,
	// event pulses
	output logic hit_evt,
	output logic miss_evt
);

	localparam int TAG_BITS = $bits(icache_pkg::line_tag_t);

	icache_pkg::ctrl_state_t state;
	icache_pkg::ctrl_state_t state_next;
	// fence seen while busy
	logic fence_pend;
	// line aligned address of the outstanding miss
	icache_pkg::fetch_addr_t miss_addr;
	// word and response held for ST_RETURN
	icache_pkg::inst_word_t ret_data;
	icache_pkg::axi_resp_t ret_resp;

	logic idle;
	logic accept;
	logic idle_hit;
	logic last_beat;

	// ------------------------------------------------------------------------
	// handshakes
	// ------------------------------------------------------------------------
	assign idle = (state == icache_pkg::ST_IDLE);
	// no request taken while a fence is pending or arriving
	assign ifu_arready = idle && !fence_i && !fence_pend;
	assign accept = ifu_arvalid && ifu_arready;
	assign idle_hit = accept && lookup.hit;
	assign last_beat = out_rvalid && out_rready && out_rlast;

	// index and tag from the live request address
	assign rd_index = ifu_araddr[`ICACHE_OFFSET_BITS +: `ICACHE_INDEX_BITS];
	assign rd_tag = ifu_araddr[`ICACHE_ADDR_BITS-1 -: TAG_BITS];

	// hit answers in the same cycle, everything else from the latch
	assign ifu_rvalid = idle_hit || (state == icache_pkg::ST_RETURN);
	assign ifu_rdata = idle_hit ? lookup.data : ret_data;
	assign ifu_rresp = idle_hit ? `ICACHE_RESP_OKAY : ret_resp;

	assign out_araddr = miss_addr;
	assign out_arvalid = (state == icache_pkg::ST_REQ);
	assign out_rready = (state == icache_pkg::ST_FILL);

	// error beats are forwarded but never written
	always_comb begin
		fill.en = last_beat && (out_rresp == `ICACHE_RESP_OKAY);
		fill.index = miss_addr[`ICACHE_OFFSET_BITS +: `ICACHE_INDEX_BITS];
		fill.tag = miss_addr[`ICACHE_ADDR_BITS-1 -: TAG_BITS];
		fill.data = out_rdata;
	end

	assign flush = idle && (fence_i || fence_pend);
	assign hit_evt = idle_hit;
	assign miss_evt = accept && !lookup.hit;

	// ------------------------------------------------------------------------
	// state machine
	// ------------------------------------------------------------------------
	always_comb begin
		state_next = state;
		case (state)
			icache_pkg::ST_IDLE: begin
				if (accept) begin
					if (!lookup.hit) begin
						state_next = icache_pkg::ST_REQ;
					end else if (!ifu_rready) begin
						// fetch unit stalled, park the word
						state_next = icache_pkg::ST_RETURN;
					end
				end
			end
			icache_pkg::ST_RETURN: begin
				if (ifu_rready) begin
					state_next = icache_pkg::ST_IDLE;
				end
			end
			icache_pkg::ST_REQ: begin
				if (out_arready) begin
					state_next = icache_pkg::ST_FILL;
				end
			end
			icache_pkg::ST_FILL: begin
				if (last_beat) begin
					state_next = icache_pkg::ST_RETURN;
				end
			end
			default: state_next = icache_pkg::ST_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= icache_pkg::ST_IDLE;
			fence_pend <= 1'b0;
		end else begin
			state <= state_next;
			// remembered while busy, done on the first idle cycle
			if (idle) begin
				fence_pend <= 1'b0;
			end else if (fence_i) begin
				fence_pend <= 1'b1;
			end
		end
	end

	// ------------------------------------------------------------------------
	// address and return latches
	// ------------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (miss_evt) begin
			miss_addr <= {ifu_araddr[`ICACHE_ADDR_BITS-1:`ICACHE_OFFSET_BITS],
				{`ICACHE_OFFSET_BITS{1'b0}}};
		end
		if (idle_hit && !ifu_rready) begin
			ret_data <= lookup.data;
			ret_resp <= `ICACHE_RESP_OKAY;
		end
		if (out_rvalid && out_rready) begin
			ret_data <= out_rdata;
			ret_resp <= out_rresp;
		end
	end

endmodule

//--- source/icache_store.sv
`include "icache_settings.svh"

module icache_store (
	input logic clk,
	input logic rst,
	input icache_pkg::line_index_t rd_index,
	input icache_pkg::line_tag_t rd_tag,
	output icache_pkg::lookup_t lookup,
	input icache_pkg::fill_t fill,
	input logic flush
);

	localparam int LINES = 1 << `ICACHE_INDEX_BITS;

	// ------------------------------------------------------------------------
	// line storage
	// ------------------------------------------------------------------------
	icache_pkg::inst_word_t data_q [LINES];
	icache_pkg::line_tag_t tag_q [LINES];
	// one valid bit per line
	logic [LINES-1:0] valid_q;

	// ------------------------------------------------------------------------
	// lookup
	// ------------------------------------------------------------------------
	// purely combinational, hit seen in the request cycle
	always_comb begin
		lookup.hit = valid_q[rd_index] && (tag_q[rd_index] == rd_tag);
		lookup.data = data_q[rd_index];
	end

	// ------------------------------------------------------------------------
	// fill and flush
	// ------------------------------------------------------------------------
	// word and tag written together with the fill
	always_ff @(posedge clk) begin
		if (fill.en) begin
			data_q[fill.index] <= fill.data;
			tag_q[fill.index] <= fill.tag;
		end
	end

	// valid vector
	always_ff @(posedge clk) begin
		if (rst) begin
			valid_q <= '0;
		end else if (flush) begin
			// fence clears every line at once
			valid_q <= '0;
		end else if (fill.en) begin
			valid_q[fill.index] <= 1'b1;
		end
	end

endmodule

//--- source/icache_pkg.sv
`include "icache_settings.svh"

package icache_pkg;

	// ------------------------------------------------------------------------
	// vector types
	// ------------------------------------------------------------------------
	typedef logic [`ICACHE_ADDR_BITS-1:0] fetch_addr_t;
	typedef logic [31:0] inst_word_t;
	typedef logic [1:0] axi_resp_t;
	typedef logic [`ICACHE_INDEX_BITS-1:0] line_index_t;
	// tag is whatever is left above index and offset
	typedef logic [`ICACHE_ADDR_BITS-`ICACHE_INDEX_BITS-`ICACHE_OFFSET_BITS-1:0] line_tag_t;
	typedef logic [31:0] perf_cnt_t;

	// controller states
	typedef enum logic [1:0] {
		ST_IDLE,
		ST_RETURN,
		ST_REQ,
		ST_FILL
	} ctrl_state_t;

	// result of the combinational tag compare
	typedef struct packed {
		logic hit;
		inst_word_t data;
	} lookup_t;

	// line write from the controller, en gates the whole write
	typedef struct packed {
		logic en;
		line_index_t index;
		line_tag_t tag;
		inst_word_t data;
	} fill_t;

endpackage

//--- include/icache_settings.svh
`ifndef ICACHE_SETTINGS_SVH
`define ICACHE_SETTINGS_SVH

// fetch address width in bits
`define ICACHE_ADDR_BITS 32

// 16 lines, one word each
`define ICACHE_INDEX_BITS 4

// byte offset inside a one-word line
`define ICACHE_OFFSET_BITS 2

// read response code for a good transfer
`define ICACHE_RESP_OKAY 2'b00

`endif
